/* common/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // ==============================
    // sizes and timing
    // ==============================
    localparam int WORD_W     = 32;
    localparam int RST_HOLD   = 16;   // cycles of reset stretch
    localparam int UART_DIV   = 8;    // clocks per uart bit, small for sim
    localparam int UART_BITS  = 8;    // data bits per frame, 8N1
    localparam int SW_WIDTH   = 18;
    localparam int LEDR_WIDTH = 18;
    localparam int LEDG_WIDTH = 9;
    localparam int NUM_DIGITS = 8;    // seven-segment digits on the board

    // counter widths derived from the above
    localparam int RST_CNT_W  = $clog2(RST_HOLD + 1);
    localparam int UART_CNT_W = (UART_DIV > 1) ? $clog2(UART_DIV) : 1;

    // status register bit positions
    localparam int STAT_BUSY = 0;
    localparam int STAT_OVR  = 1;
    localparam int STAT_IRQ  = 2;

    // ==============================
    // bus types
    // ==============================
    typedef logic [WORD_W-1:0] word_t;

    // one word per address, unlisted codes read zero
    typedef enum logic [2:0] {
        REG_LED       = 3'd0,     // r/w led word
        REG_SW        = 3'd1,     // ro switches
        REG_UART_DATA = 3'd2,     // wo tx byte
        REG_UART_STAT = 3'd3      // busy / overrun / irq
    } reg_addr_e;

    typedef struct packed {
        logic      wr;            // one-cycle write strobe
        logic      rd;            // one-cycle read strobe
        reg_addr_e addr;
        word_t     wdata;
    } bus_req_t;

    typedef struct packed {
        logic  rvalid;            // one-cycle pulse
        word_t rdata;
    } bus_rsp_t;

    // uart transmitter states
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

    // display, active low, bit 0 is segment a
    typedef logic [6:0] seg_t;
    typedef seg_t [NUM_DIGITS-1:0] hex_digits_t;   // digit 0 = led_word[3:0]

endpackage

`default_nettype wire

/* logic/clk_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_ctrl (
    input  logic clk,
    input  logic reset,        // external reset, active high
    input  logic pll_locked,
    input  logic key0_n,       // push-button, active low
    output logic sys_reset
);

    // ==============================
    // reset sources
    // ==============================
    logic                          src_active;
    logic [soc_pkg::RST_CNT_W-1:0] hold_cnt;

    // any one source restarts the hold
    assign src_active = reset | ~pll_locked | ~key0_n;

    // ==============================
    // hold counter
    // ==============================
    // counter reloads as long as a source is active, so a short glitch on
    // the button or the lock still gives the full stretch
    always_ff @(posedge clk) begin
        if (src_active) begin
            hold_cnt  <= soc_pkg::RST_CNT_W'(soc_pkg::RST_HOLD);
            sys_reset <= 1'b1;
        end else begin
            if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;          // count down to zero
            end
            sys_reset <= (hold_cnt != '0);            // release once empty
        end
    end

endmodule

`default_nettype wire

/* periph/periph_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  soc_pkg::bus_req_t             bus_req,
    output soc_pkg::bus_rsp_t             bus_rsp,
    input  logic [soc_pkg::SW_WIDTH-1:0]  sw,
    input  logic                          irq_level,
    output soc_pkg::word_t                led_word,
    output logic                          tx_start,
    output logic [soc_pkg::UART_BITS-1:0] tx_byte,
    input  logic                          tx_busy
);

    // synchronizers
    logic [soc_pkg::SW_WIDTH-1:0] sw_meta;
    logic [soc_pkg::SW_WIDTH-1:0] sw_sync;
    logic                         irq_q;

    // write side
    logic tx_pending;       // busy, or start already issued this cycle
    logic uart_wr;
    logic uart_accept;
    logic uart_drop;
    logic overrun;          // sticky
    logic stat_rd_done;

    // read pipeline
    logic                rd_pend;
    soc_pkg::reg_addr_e  rd_addr;
    soc_pkg::word_t      rd_mux;
    logic                rvalid_q;
    soc_pkg::word_t      rdata_q;

    // ==============================
    // input synchronizers
    // ==============================
    always_ff @(posedge clk) begin
        sw_meta <= sw;          // first flop
        sw_sync <= sw_meta;     // second flop, safe to read
        irq_q   <= irq_level;   // status irq bit
    end

    // ==============================
    // write decode
    // ==============================
    // the start pulse counts as busy, the uart only raises busy a cycle later
    assign tx_pending  = tx_busy | tx_start;
    assign uart_wr     = bus_req.wr && (bus_req.addr == soc_pkg::REG_UART_DATA);
    assign uart_accept = uart_wr && !tx_pending;
    assign uart_drop   = uart_wr && tx_pending;      // no back-pressure, lost
    assign stat_rd_done = rd_pend && (rd_addr == soc_pkg::REG_UART_STAT);

    always_ff @(posedge clk) begin
        if (reset) begin
            led_word <= '0;
            tx_start <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            tx_start <= uart_accept;                 // single-cycle pulse
            if (bus_req.wr && (bus_req.addr == soc_pkg::REG_LED)) begin
                led_word <= bus_req.wdata;
            end
            // cleared by the status read that returns it
            if (stat_rd_done) begin
                overrun <= 1'b0;
            end
            if (uart_drop) begin
                overrun <= 1'b1;                     // a fresh drop wins
            end
        end
    end

    // byte held until the uart loads it
    always_ff @(posedge clk) begin
        if (uart_accept) begin
            tx_byte <= bus_req.wdata[soc_pkg::UART_BITS-1:0];
        end
    end

    // ==============================
    // read path, two stages
    // ==============================
    always_comb begin
        rd_mux = '0;                                 // unused addresses
        case (rd_addr)
            soc_pkg::REG_LED: rd_mux = led_word;
            soc_pkg::REG_SW:  rd_mux[soc_pkg::SW_WIDTH-1:0] = sw_sync;
            soc_pkg::REG_UART_STAT: begin
                rd_mux[soc_pkg::STAT_BUSY] = tx_pending;
                rd_mux[soc_pkg::STAT_OVR]  = overrun;
                rd_mux[soc_pkg::STAT_IRQ]  = irq_q;
            end
            default: ;                               // uart data is write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pend  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            rd_pend  <= bus_req.rd;     // stage 1, strobe seen
            rvalid_q <= rd_pend;        // stage 2, data out
        end
    end

    always_ff @(posedge clk) begin
        rd_addr <= bus_req.addr;
        if (rd_pend) begin
            rdata_q <= rd_mux;
        end
    end

    assign bus_rsp.rvalid = rvalid_q;
    assign bus_rsp.rdata  = rdata_q;

endmodule

`default_nettype wire

/* periph/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          tx_start,
    input  logic [soc_pkg::UART_BITS-1:0] tx_byte,
    output logic                          tx_busy,
    output logic                          txd
);

    soc_pkg::uart_state_e                     state;
    logic [soc_pkg::UART_CNT_W-1:0]           baud_cnt;
    logic [$clog2(soc_pkg::UART_BITS)-1:0]    bit_idx;
    logic [soc_pkg::UART_BITS-1:0]            shreg;
    logic                                     bit_end;
    logic                                     load;
    logic                                     shift;

    // last clock of the current bit
    assign bit_end = (baud_cnt == soc_pkg::UART_CNT_W'(soc_pkg::UART_DIV - 1));
    assign load    = (state == soc_pkg::UART_IDLE) && tx_start;
    // next data bit goes out at the end of start or of a non-final data bit
    assign shift   = bit_end && ((state == soc_pkg::UART_START) ||
                     ((state == soc_pkg::UART_DATA) &&
                      (bit_idx != $bits(bit_idx)'(soc_pkg::UART_BITS - 1))));

    // ==============================
    // frame fsm
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= soc_pkg::UART_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx_busy  <= 1'b0;
            txd      <= 1'b1;           // line idles high
        end else if (state == soc_pkg::UART_IDLE) begin
            if (tx_start) begin
                state    <= soc_pkg::UART_START;
                baud_cnt <= '0;
                tx_busy  <= 1'b1;
                txd      <= 1'b0;       // start bit
            end
        end else begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            if (bit_end) begin
                case (state)
                    soc_pkg::UART_START: begin
                        state   <= soc_pkg::UART_DATA;
                        bit_idx <= '0;
                        txd     <= shreg[0];            // lsb first
                    end
                    soc_pkg::UART_DATA: begin
                        if (bit_idx == $bits(bit_idx)'(soc_pkg::UART_BITS - 1)) begin
                            state <= soc_pkg::UART_STOP;
                            txd   <= 1'b1;              // stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= shreg[0];
                        end
                    end
                    default: begin                      // stop done
                        state   <= soc_pkg::UART_IDLE;
                        tx_busy <= 1'b0;
                    end
                endcase
            end
        end
    end

    // data shifter, bit 0 always holds the next bit to send
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= tx_byte;
        end else if (shift) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

`default_nettype wire

/* display/seg7_lut8.sv */
`timescale 1ns/1ps
`default_nettype none

module seg7_lut8 (
    input  soc_pkg::word_t       value,
    output soc_pkg::hex_digits_t hex
);

    // hex nibble to segments, active low, bit 0 = a
    function automatic soc_pkg::seg_t hex_to_seg(input logic [3:0] nib);
        soc_pkg::seg_t seg;
        case (nib)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;     // all on
            4'h9: seg = 7'b0010000;
            4'ha: seg = 7'b0001000;
            4'hb: seg = 7'b0000011;     // lower case b
            4'hc: seg = 7'b1000110;
            4'hd: seg = 7'b0100001;     // lower case d
            4'he: seg = 7'b0000110;
            default: seg = 7'b0001110;  // F
        endcase
        return seg;
    endfunction

    // ==============================
    // one decoder per digit
    // ==============================
    for (genvar d = 0; d < soc_pkg::NUM_DIGITS; d++) begin : g_digit
        assign hex[d] = hex_to_seg(value[4*d +: 4]);   // digit d shows nibble d
    end

endmodule

`default_nettype wire

/* logic/soc_toplevel.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_toplevel (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           pll_locked,
    input  logic [3:0]                     key,        // active low buttons
    input  logic [soc_pkg::SW_WIDTH-1:0]   sw,
    input  logic                           irq_in,
    input  soc_pkg::bus_req_t              bus_req,
    output soc_pkg::bus_rsp_t              bus_rsp,
    output logic [soc_pkg::LEDR_WIDTH-1:0] ledr,
    output logic [soc_pkg::LEDG_WIDTH-1:0] ledg,
    output soc_pkg::hex_digits_t           hex,
    output logic                           uart_txd,
    output logic                           phy_rst_n
);

    logic                          sys_reset;
    logic                          irq_level;
    soc_pkg::word_t                led_word;
    logic                          tx_start;
    logic [soc_pkg::UART_BITS-1:0] tx_byte;
    logic                          tx_busy;

    // ==============================
    // reset and glue
    // ==============================
    clk_ctrl u_clk_ctrl (
        .clk        (clk),
        .reset      (reset),
        .pll_locked (pll_locked),
        .key0_n     (key[0]),           // button 0 is the board reset
        .sys_reset  (sys_reset)
    );

    assign phy_rst_n = ~sys_reset;                  // phy held with the system
    assign irq_level = irq_in & key[1];             // key 1 masks the irq

    // ==============================
    // peripherals
    // ==============================
    periph_regs u_periph_regs (
        .clk       (clk),
        .reset     (sys_reset),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .sw        (sw),
        .irq_level (irq_level),
        .led_word  (led_word),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .tx_busy   (tx_busy)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .reset    (sys_reset),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .txd      (uart_txd)
    );

    seg7_lut8 u_seg7_lut8 (
        .value (led_word),
        .hex   (hex)
    );

    // green leds take the low bits, red the next ones up
    assign ledg = led_word[soc_pkg::LEDG_WIDTH-1:0];
    assign ledr = led_word[soc_pkg::LEDG_WIDTH +: soc_pkg::LEDR_WIDTH];

endmodule

`default_nettype wire

/* tests/soc_toplevel_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_toplevel_assert (
    input logic              clk,
    input logic              reset,
    input logic              phy_rst_n,
    input logic              tx_busy,
    input logic              uart_txd,
    input soc_pkg::bus_req_t bus_req,
    input soc_pkg::bus_rsp_t bus_rsp
);

    int assert_errors = 0;          // failed assertion count

    // ==============================
    // uart and bus
    // ==============================
    // line idles high outside a frame
    a_txd_idle: assert property (@(posedge clk) disable iff (reset)
        !tx_busy |-> uart_txd)
        else begin
            $error("uart line low while the transmitter is idle");
            assert_errors++;
        end

    // strobe then pending stage then rvalid
    a_rvalid_cause: assert property (@(posedge clk) disable iff (reset)
        $rose(bus_rsp.rvalid) |-> $past(bus_req.rd, 2))
        else begin
            $error("read valid without a read strobe");
            assert_errors++;
        end

    // ==============================
    // reset
    // ==============================
    a_phy_reset: assert property (@(posedge clk)
        reset |=> !phy_rst_n)           // one register in clk_ctrl
        else begin
            $error("phy reset released during external reset");
            assert_errors++;
        end

endmodule

bind soc_toplevel soc_toplevel_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .phy_rst_n (phy_rst_n),
    .tx_busy   (tx_busy),
    .uart_txd  (uart_txd),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp)
);

`default_nettype wire

/* tests/tb_soc_toplevel.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_toplevel;

    localparam int REL_EDGES   = soc_pkg::RST_HOLD + 1;   // first clean edge then the hold
    localparam int WAIT_LIMIT  = 64;                      // short waits in cycles
    localparam int FRAME_LIMIT = 4 * soc_pkg::UART_DIV;   // start bit search

    logic                           clk;
    logic                           reset;
    logic                           pll_locked;
    logic [3:0]                     key;
    logic [soc_pkg::SW_WIDTH-1:0]   sw;
    logic                           irq_in;
    soc_pkg::bus_req_t              bus_req;
    soc_pkg::bus_rsp_t              bus_rsp;
    logic [soc_pkg::LEDR_WIDTH-1:0] ledr;
    logic [soc_pkg::LEDG_WIDTH-1:0] ledg;
    soc_pkg::hex_digits_t           hex;
    logic                           uart_txd;
    logic                           phy_rst_n;
    int                             value_errors = 0;
    int                             timeout_errors = 0;

    soc_toplevel u_dut (
        .clk        (clk),
        .reset      (reset),
        .pll_locked (pll_locked),
        .key        (key),
        .sw         (sw),
        .irq_in     (irq_in),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .ledr       (ledr),
        .ledg       (ledg),
        .hex        (hex),
        .uart_txd   (uart_txd),
        .phy_rst_n  (phy_rst_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_word(input string test, input soc_pkg::word_t exp,
                              input soc_pkg::word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", test, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_hex(input string test, input soc_pkg::hex_digits_t exp,
                             input soc_pkg::hex_digits_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", test, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_byte(input string test, input logic [soc_pkg::UART_BITS-1:0] exp,
                              input logic [soc_pkg::UART_BITS-1:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", test, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", test, exp, act);
            value_errors++;
        end
    endtask

    // lit segments per hex digit turned into the active low code
    function automatic soc_pkg::seg_t segments_for(input logic [3:0] nib);
        string         lit;
        soc_pkg::seg_t s;
        case (nib)
            4'h0: lit = "abcdef";
            4'h1: lit = "bc";
            4'h2: lit = "abdeg";
            4'h3: lit = "abcdg";
            4'h4: lit = "bcfg";
            4'h5: lit = "acdfg";
            4'h6: lit = "acdefg";
            4'h7: lit = "abc";
            4'h8: lit = "abcdefg";
            4'h9: lit = "abcdfg";
            4'ha: lit = "abcefg";
            4'hb: lit = "cdefg";    // lower case
            4'hc: lit = "adef";
            4'hd: lit = "bcdeg";    // lower case
            4'he: lit = "adefg";
            default: lit = "aefg";
        endcase
        s = '1;                     // all dark
        for (int i = 0; i < lit.len(); i++) begin
            s &= ~(7'b1 << (lit[i] - "a"));
        end
        return s;
    endfunction

    function automatic soc_pkg::hex_digits_t expected_hex(input soc_pkg::word_t w);
        soc_pkg::hex_digits_t h;
        for (int d = 0; d < soc_pkg::NUM_DIGITS; d++) begin
            h[d] = segments_for(w[4*d +: 4]);
        end
        return h;
    endfunction

    // ==============================
    // bus tasks
    // ==============================
    task automatic bus_write(input soc_pkg::reg_addr_e addr, input soc_pkg::word_t data);
        soc_pkg::bus_req_t req;
        req       = '0;
        req.wr    = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        @(posedge clk);
        bus_req <= req;
        @(posedge clk);             // write sampled here
        bus_req <= '0;
    endtask

    task automatic bus_read(input soc_pkg::reg_addr_e addr, output soc_pkg::word_t data);
        soc_pkg::bus_req_t req;
        logic              got;
        req      = '0;
        req.rd   = 1'b1;
        req.addr = addr;
        got      = 1'b0;
        data     = '0;
        @(posedge clk);
        bus_req <= req;
        @(posedge clk);
        bus_req <= '0;
        for (int i = 0; i < WAIT_LIMIT && !got; i++) begin
            @(negedge clk);
            if (bus_rsp.rvalid) begin
                data = bus_rsp.rdata;
                got  = 1'b1;
            end
        end
        if (!got) begin
            $display("TIMEOUT: no read response for address %0d", addr);
            timeout_errors++;
        end
    endtask

    // counts edges from the release drive until phy_rst_n comes up
    task automatic measure_release(input string test);
        int   edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < WAIT_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            seen = phy_rst_n;
        end
        if (!seen) begin
            $display("TIMEOUT: %s, phy reset never released", test);
            timeout_errors++;
        end else begin
            check_word(test, soc_pkg::word_t'(REL_EDGES), soc_pkg::word_t'(edges));
        end
    endtask

    // drops key 0 or the pll lock for two cycles
    task automatic drop_source(input string test, input logic use_pll);
        @(posedge clk);
        if (use_pll) pll_locked <= 1'b0;
        else key[0] <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit({test, " phy low"}, 1'b0, phy_rst_n);
        @(posedge clk);
        if (use_pll) pll_locked <= 1'b1;
        else key[0] <= 1'b1;
        measure_release(test);
    endtask

    // waits for the start bit edge and samples each bit centre
    task automatic capture_frame(input string test, output logic [7:0] data,
                                 output logic ok);
        logic       prev;
        logic       found;
        logic [7:0] rx;
        prev  = 1'b1;
        found = 1'b0;
        rx    = '0;
        ok    = 1'b0;
        data  = '0;
        for (int i = 0; i < FRAME_LIMIT && !found; i++) begin
            @(negedge clk);
            found = prev && !uart_txd;
            prev  = uart_txd;
        end
        if (!found) begin
            $display("TIMEOUT: %s, no start bit on the uart line", test);
            timeout_errors++;
            return;
        end
        repeat (soc_pkg::UART_DIV / 2) @(negedge clk);   // middle of start bit
        check_bit({test, " start"}, 1'b0, uart_txd);
        for (int b = 0; b < 8; b++) begin
            repeat (soc_pkg::UART_DIV) @(negedge clk);
            rx[b] = uart_txd;                            // lsb first
        end
        repeat (soc_pkg::UART_DIV) @(negedge clk);
        check_bit({test, " stop"}, 1'b1, uart_txd);
        data = rx;
        ok   = 1'b1;
    endtask

    // ==============================
    // directed tests
    // ==============================
    task automatic test_reset_hold();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        measure_release("reset_hold ext");
        check_bit("reset_hold rvalid", 1'b0, bus_rsp.rvalid);
        check_bit("reset_hold txd", 1'b1, uart_txd);
        check_hex("reset_hold hex", expected_hex('0), hex);   // all zeros shown
        drop_source("reset_hold key0", 1'b0);
        drop_source("reset_hold pll", 1'b1);
    endtask

    task automatic test_led_display();
        soc_pkg::word_t w;
        soc_pkg::word_t got;
        repeat (4) begin
            w = $urandom();
            bus_write(soc_pkg::REG_LED, w);
            @(negedge clk);
            check_word("led_display ledg", soc_pkg::word_t'(w[8:0]), soc_pkg::word_t'(ledg));
            check_word("led_display ledr", soc_pkg::word_t'(w[26:9]), soc_pkg::word_t'(ledr));
            check_hex("led_display hex", expected_hex(w), hex);
            bus_read(soc_pkg::REG_LED, got);
            check_word("led_display read", w, got);
        end
    endtask

    task automatic test_switch_read();
        soc_pkg::word_t               rnd;
        soc_pkg::word_t               got;
        logic [soc_pkg::SW_WIDTH-1:0] swv;
        repeat (3) begin
            rnd = $urandom();
            swv = rnd[soc_pkg::SW_WIDTH-1:0];
            @(posedge clk);
            sw <= swv;
            repeat (3) @(posedge clk);                   // through the synchronizer
            bus_read(soc_pkg::REG_SW, got);
            check_word("switch_read", soc_pkg::word_t'(swv), got);
        end
        for (int a = 4; a < 8; a++) begin
            bus_read(soc_pkg::reg_addr_e'(a), got);
            check_word("switch_read unused", '0, got);
        end
    endtask

    task automatic test_uart_frame();
        logic [7:0]     tx;
        logic [7:0]     rx;
        logic           ok;
        soc_pkg::word_t stat;
        tx = 8'($urandom());
        bus_write(soc_pkg::REG_UART_DATA, soc_pkg::word_t'(tx));
        fork
            capture_frame("uart_frame", rx, ok);
            begin
                repeat (3 * soc_pkg::UART_DIV) @(posedge clk);   // mid frame
                bus_read(soc_pkg::REG_UART_STAT, stat);
                check_bit("uart_frame busy", 1'b1, stat[soc_pkg::STAT_BUSY]);
            end
        join
        if (ok) check_byte("uart_frame data", tx, rx);
        repeat (soc_pkg::UART_DIV) @(posedge clk);             // stop bit ends
        bus_read(soc_pkg::REG_UART_STAT, stat);
        check_bit("uart_frame idle", 1'b0, stat[soc_pkg::STAT_BUSY]);
        check_bit("uart_frame txd", 1'b1, uart_txd);
    endtask

    task automatic test_overrun();
        logic [7:0]     first;
        logic [7:0]     second;
        logic [7:0]     rx;
        logic           ok;
        logic           quiet;
        soc_pkg::word_t stat;
        first  = 8'($urandom());
        second = 8'($urandom());
        quiet  = 1'b1;
        bus_write(soc_pkg::REG_UART_DATA, soc_pkg::word_t'(first));
        fork
            capture_frame("overrun", rx, ok);
            bus_write(soc_pkg::REG_UART_DATA, soc_pkg::word_t'(second));  // dropped
        join
        if (ok) check_byte("overrun first", first, rx);
        repeat (12 * soc_pkg::UART_DIV) begin                 // longer than a frame
            @(negedge clk);
            if (!uart_txd) quiet = 1'b0;
        end
        check_bit("overrun no second frame", 1'b1, quiet);
        bus_read(soc_pkg::REG_UART_STAT, stat);
        check_bit("overrun set", 1'b1, stat[soc_pkg::STAT_OVR]);
        bus_read(soc_pkg::REG_UART_STAT, stat);
        check_bit("overrun cleared", 1'b0, stat[soc_pkg::STAT_OVR]);
    endtask

    task automatic test_irq_level();
        soc_pkg::word_t stat;
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            irq_in <= c[0];
            key[1] <= c[1];                              // key 1 gates the irq
            repeat (2) @(posedge clk);
            bus_read(soc_pkg::REG_UART_STAT, stat);
            check_bit("irq_level", c[0] & c[1], stat[soc_pkg::STAT_IRQ]);
        end
        @(posedge clk);
        key[1] <= 1'b1;
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        void'($urandom(63204));
        reset      <= 1'b1;
        pll_locked <= 1'b1;
        key        <= 4'hf;          // buttons released
        sw         <= '0;
        irq_in     <= 1'b0;
        bus_req    <= '0;
        test_reset_hold();
        test_led_display();
        test_switch_read();
        test_uart_frame();
        test_overrun();
        test_irq_level();
        repeat (4) @(posedge clk);
        $display("errors: %0d value, %0d timeout, %0d assertion", value_errors,
                 timeout_errors, u_dut.u_assert.assert_errors);
        if (value_errors + timeout_errors + u_dut.u_assert.assert_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
common/soc_pkg.sv
logic/clk_ctrl.sv
periph/periph_regs.sv
periph/uart_tx.sv
display/seg7_lut8.sv
logic/soc_toplevel.sv
tests/soc_toplevel_assert.sv
tests/tb_soc_toplevel.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_soc_toplevel
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
